// ==== acq_top.f ====
+incdir+include
source/acq_pkg.sv
source/sample_sequencer.sv
source/window_pulse_counter.sv
source/sample_fifo.sv
source/az_subtract.sv
source/acq_top.sv
bench/acq_tb.sv

// ==== bench/acq_tb.sv ====
/*
  testbench for the acquisition top level
  clock, reset, lfsr converter pulses, reference model, result compare, watchdog
*/

`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module acq_tb;

  // first and second run settings
  localparam int SD1    = 20;
  localparam int PC1    = 5;
  localparam int SD2    = 7;
  localparam int PC2    = 2;
  localparam int PAIRS1 = 7;
  localparam int PAIRS2 = 5;
  localparam int QUIET  = 500;
  localparam logic [`ACQ_AZMUX_W-1:0] LO_CODE = 4'd3;

  // cycles for one hi/lo pair from cycle end round to cycle end
  localparam int PAIR_CYC1 = 2 * SD1 + 2 * PC1 + 9;
  localparam int PAIR_CYC2 = 2 * SD2 + 2 * PC2 + 9;
  localparam int LIMIT = PAIRS1 * PAIR_CYC1 + PAIRS2 * PAIR_CYC2 + 10 + QUIET + 200;

  logic                         clk;
  logic                         reset;
  logic                         run;
  logic                         vf_pulse;
  logic [`ACQ_DUR_W-1:0]        sample_duration;
  logic [`ACQ_PC_W-1:0]         precharge_count;
  logic [`ACQ_AZMUX_W-1:0]      azmux_lo_val;
  wire                          sw_pc_ctl;
  wire                          led0;
  wire [`ACQ_AZMUX_W-1:0]       azmux;
  wire                          result_valid;
  acq_pkg::az_result_t          result;
  wire [3:0]                    monitor;

  logic [31:0]                  lfsr = 32'h7df1;
  int                           cur_dur;
  int                           hi_len;
  int                           lo_len;
  int                           hi_acc;
  int                           lo_acc;
  int                           hi_q[$];
  int                           exp_q[$];
  int                           results_seen;
  int                           negatives;
  int                           expected;
  logic signed [`ACQ_COUNT_W:0] got_diff;
  // no window and no result allowed while set
  logic                         quiet;
  logic [`ACQ_AZMUX_W-1:0]      prev_azmux;

  acq_top dut0 (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .vf_pulse        (vf_pulse),
    .sample_duration (sample_duration),
    .precharge_count (precharge_count),
    .azmux_lo_val    (azmux_lo_val),
    .sw_pc_ctl       (sw_pc_ctl),
    .led0            (led0),
    .azmux           (azmux),
    .result_valid    (result_valid),
    .result          (result),
    .monitor         (monitor)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // 32 bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // auto-zeroed reading is the hi count minus the lo count
  function automatic int az_expect(input int hi, input int lo);
    return hi - lo;
  endfunction

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one lfsr step per converter pulse bit
  always @(negedge clk)
  begin
    lfsr     = lfsr_next(lfsr);
    vf_pulse = lfsr[0];
  end

  //////////////////////////////////////////////////////////////////////
  // window monitor and reference model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!reset)
    begin
      assert (monitor[3] == 1'b0)
        else fail_stop($sformatf("ERR %0t monitor[3] expected 0 got %0b", $time, monitor[3]));
      assert (!(quiet && (monitor[1] || monitor[2] || result_valid)))
        else fail_stop("a window opened or a result came out while run was low");
      // azmux frozen while the switch passes the signal
      if (sw_pc_ctl == `ACQ_SW_PC_SIGNAL)
        assert (azmux == prev_azmux)
          else fail_stop($sformatf("ERR %0t azmux expected %0h got %0h",
                                   $time, prev_azmux, azmux));
      prev_azmux = azmux;

      // count pulses and check drives in the hi window
      if (monitor[1])
      begin
        assert (sw_pc_ctl == `ACQ_SW_PC_SIGNAL)
          else fail_stop($sformatf("ERR %0t sw_pc_ctl expected %0b got %0b",
                                   $time, `ACQ_SW_PC_SIGNAL, sw_pc_ctl));
        assert (azmux == `ACQ_AZMUX_HI)
          else fail_stop($sformatf("ERR %0t azmux expected %0h got %0h",
                                   $time, `ACQ_AZMUX_HI, azmux));
        // azmux sits on the pre-charge output
        assert (monitor[0] == 1'b1)
          else fail_stop($sformatf("ERR %0t monitor[0] expected 1 got %0b",
                                   $time, monitor[0]));
        hi_len = hi_len + 1;
        if (vf_pulse)
          hi_acc = hi_acc + 1;
      end
      else if (hi_len != 0)
      begin
        assert (hi_len == cur_dur + 1)
          else fail_stop($sformatf("ERR %0t hi window length expected %0d got %0d",
                                   $time, cur_dur + 1, hi_len));
        hi_q.push_back(hi_acc);
        hi_len = 0;
        hi_acc = 0;
      end

      // lo window
      if (monitor[2])
      begin
        assert (sw_pc_ctl == `ACQ_SW_PC_BOOT)
          else fail_stop($sformatf("ERR %0t sw_pc_ctl expected %0b got %0b",
                                   $time, `ACQ_SW_PC_BOOT, sw_pc_ctl));
        assert (azmux == azmux_lo_val)
          else fail_stop($sformatf("ERR %0t azmux expected %0h got %0h",
                                   $time, azmux_lo_val, azmux));
        // lo code is not the pre-charge code
        assert (monitor[0] == 1'b0)
          else fail_stop($sformatf("ERR %0t monitor[0] expected 0 got %0b",
                                   $time, monitor[0]));
        lo_len = lo_len + 1;
        if (vf_pulse)
          lo_acc = lo_acc + 1;
      end
      else if (lo_len != 0)
      begin
        assert (lo_len == cur_dur + 1)
          else fail_stop($sformatf("ERR %0t lo window length expected %0d got %0d",
                                   $time, cur_dur + 1, lo_len));
        assert (hi_q.size() != 0)
          else fail_stop("a lo window closed with no hi window before it");
        // queue the expected reading once the pair is complete
        exp_q.push_back(az_expect(hi_q.pop_front(), lo_acc));
        lo_len = 0;
        lo_acc = 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result compare
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!reset && result_valid)
    begin
      assert (exp_q.size() != 0)
        else fail_stop("result_valid pulsed with no completed hi/lo pair");
      expected = exp_q.pop_front();
      got_diff = result.diff;
      assert (got_diff == expected)
        else fail_stop($sformatf("ERR %0t result.diff expected %0d got %0d",
                                 $time, expected, got_diff));
      results_seen = results_seen + 1;
      if (got_diff < 0)
        negatives = negatives + 1;
    end
  end

  // watchdog sized from the pair lengths
  initial
  begin
    repeat (LIMIT) @(posedge clk);
    fail_stop($sformatf("the run timed out after %0d cycles", LIMIT));
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    reset           = 1'b1;
    run             = 1'b0;
    vf_pulse        = 1'b0;
    sample_duration = SD1;
    precharge_count = PC1;
    azmux_lo_val    = LO_CODE;
    cur_dur         = SD1;
    quiet           = 1'b0;
    hi_len          = 0;
    lo_len          = 0;
    hi_acc          = 0;
    lo_acc          = 0;
    results_seen    = 0;
    negatives       = 0;
    prev_azmux      = LO_CODE;

    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);

    // idle outputs after reset
    assert (sw_pc_ctl == `ACQ_SW_PC_BOOT)
      else fail_stop($sformatf("ERR %0t sw_pc_ctl expected %0b got %0b",
                               $time, `ACQ_SW_PC_BOOT, sw_pc_ctl));
    assert (led0 == 1'b0)
      else fail_stop($sformatf("ERR %0t led0 expected 0 got %0b", $time, led0));
    assert (result_valid == 1'b0)
      else fail_stop($sformatf("ERR %0t result_valid expected 0 got %0b", $time, result_valid));
    assert (azmux == LO_CODE)
      else fail_stop($sformatf("ERR %0t azmux expected %0h got %0h", $time, LO_CODE, azmux));

    run = 1'b1;
    wait (results_seen == PAIRS1 - 1);

    // drop run part way through the next hi window
    @(negedge clk);
    while (!monitor[1])
      @(negedge clk);
    repeat (SD1 / 2) @(negedge clk);
    run = 1'b0;

    // that pair still completes, then everything stops
    wait (results_seen == PAIRS1);
    @(negedge clk);
    quiet = 1'b1;
    repeat (QUIET) @(negedge clk);
    quiet = 1'b0;

    // second run with shorter windows
    sample_duration = SD2;
    precharge_count = PC2;
    cur_dur         = SD2;
    run             = 1'b1;
    wait (results_seen == PAIRS1 + PAIRS2);
    repeat (4) @(negedge clk);

    $display("%0d of %0d results were negative", negatives, results_seen);
    if (exp_q.size() == 0 && hi_q.size() == 0 && results_seen == PAIRS1 + PAIRS2)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
      fail_stop("expected results were left unmatched at the end of the run");
  end

endmodule

`default_nettype wire

// ==== source/acq_top.sv ====
/*
  acquisition top level
  sequencer, pulse counter, record fifo, subtractor and monitor bus
*/

`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module acq_top (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       run,
  input  wire                       vf_pulse,
  input  wire [`ACQ_DUR_W-1:0]      sample_duration,
  input  wire [`ACQ_PC_W-1:0]       precharge_count,
  input  wire [`ACQ_AZMUX_W-1:0]    azmux_lo_val,
  output wire                       sw_pc_ctl,
  output wire                       led0,
  output wire [`ACQ_AZMUX_W-1:0]    azmux,
  output wire                       result_valid,
  output acq_pkg::az_result_t       result,
  output wire [3:0]                 monitor
);

  acq_pkg::seq_window_t window;
  acq_pkg::sample_rec_t push_rec;
  acq_pkg::sample_rec_t rd_rec;
  wire                  push;
  wire                  pop;
  wire                  empty;
  wire                  overflow;

  //////////////////////////////////////////////////////////////////////
  // producer, buffer, consumer
  //////////////////////////////////////////////////////////////////////

  sample_sequencer seq0 (
    .clk             (clk),
    .reset           (reset),
    .run             (run),
    .sample_duration (sample_duration),
    .precharge_count (precharge_count),
    .azmux_lo_val    (azmux_lo_val),
    .sw_pc_ctl       (sw_pc_ctl),
    .led0            (led0),
    .azmux           (azmux),
    .window          (window)
  );

  window_pulse_counter cnt0 (
    .clk      (clk),
    .reset    (reset),
    .vf_pulse (vf_pulse),
    .window   (window),
    .push     (push),
    .rec      (push_rec)
  );

  sample_fifo fifo0 (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .pop      (pop),
    .wr_rec   (push_rec),
    .rd_rec   (rd_rec),
    .empty    (empty),
    .overflow (overflow)
  );

  az_subtract sub0 (
    .clk          (clk),
    .reset        (reset),
    .empty        (empty),
    .rd_rec       (rd_rec),
    .pop          (pop),
    .result_valid (result_valid),
    .result       (result)
  );

  // overflow, lo window, hi window, azmux on pc out
  assign monitor = {
    overflow,
    window.active & (window.phase == acq_pkg::PHASE_LO),
    window.active & (window.phase == acq_pkg::PHASE_HI),
    (azmux == `ACQ_AZMUX_HI)
  };

endmodule

`default_nettype wire

// ==== source/az_subtract.sv ====
/*
  auto-zero subtractor
  pairs each hi record with the next lo record, outputs hi minus lo
*/

`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module az_subtract (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   empty,
  input  acq_pkg::sample_rec_t  rd_rec,
  output logic                  pop,
  output logic                  result_valid,
  output acq_pkg::az_result_t   result
);

  // rd_rec holds a fresh record this cycle
  logic                    rd_valid;
  // hi count waiting for its lo partner
  logic [`ACQ_COUNT_W-1:0] hi_count;
  logic                    hi_held;

  // drain whenever anything is there
  assign pop = ~empty;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rd_valid     <= 1'b0;
      hi_held      <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      rd_valid     <= pop;
      result_valid <= 1'b0;
      if (rd_valid)
      begin
        if (rd_rec.phase == acq_pkg::PHASE_HI)
          hi_held <= 1'b1;
        else if (hi_held)
        begin
          result_valid <= 1'b1;
          hi_held      <= 1'b0;
        end
        // lo with no hi in hand is dropped
      end
    end
  end

  // payload, qualified by hi_held and result_valid
  always_ff @(posedge clk)
  begin
    if (rd_valid && rd_rec.phase == acq_pkg::PHASE_HI)
      hi_count <= rd_rec.count;
    if (rd_valid && rd_rec.phase == acq_pkg::PHASE_LO && hi_held)
      result.diff <= $signed({1'b0, hi_count}) - $signed({1'b0, rd_rec.count});
  end

endmodule

`default_nettype wire

// ==== source/sample_fifo.sv ====
/*
  sample record fifo
  circular buffer with registered read port and sticky overflow flag
*/

`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module sample_fifo #(
  parameter int AW = `ACQ_FIFO_AW_DEFAULT
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   push,
  input  wire                   pop,
  input  acq_pkg::sample_rec_t  wr_rec,
  output acq_pkg::sample_rec_t  rd_rec,
  output logic                  empty,
  output logic                  overflow
);

  localparam int DEPTH = 1 << AW;

  acq_pkg::sample_rec_t mem [DEPTH];

  // one extra bit to tell full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  //////////////////////////////////////////////////////////////////////
  // pointers and flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (push && !full)
        wr_ptr <= wr_ptr + 1'b1;
      // record dropped, flag stays until reset
      if (push && full)
        overflow <= 1'b1;
      if (pop && !empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push && !full)
      mem[wr_ptr[AW-1:0]] <= wr_rec;
    // read data valid the cycle after pop
    if (pop && !empty)
      rd_rec <= mem[rd_ptr[AW-1:0]];
  end

endmodule

`default_nettype wire

// ==== source/window_pulse_counter.sv ====
/*
  window pulse counter
  counts converter pulses while the window is open, one record per window
*/

`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module window_pulse_counter (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   vf_pulse,
  input  acq_pkg::seq_window_t  window,
  output logic                  push,
  output acq_pkg::sample_rec_t  rec
);

  logic [`ACQ_COUNT_W-1:0] count;
  // delayed active, for the falling edge
  logic                    active_q;
  // phase of the window being counted
  acq_pkg::phase_t         phase_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count    <= '0;
      active_q <= 1'b0;
      phase_q  <= acq_pkg::PHASE_HI;
    end
    else
    begin
      active_q <= window.active;
      if (window.active)
      begin
        phase_q <= window.phase;
        if (vf_pulse)
          count <= count + 1'b1;
      end
      else if (push)
        // record goes out this cycle, start the next window from zero
        count <= '0;
    end
  end

  // first cycle after the window closes
  assign push      = active_q & ~window.active;
  assign rec.phase = phase_q;
  assign rec.count = count;

endmodule

`default_nettype wire

// ==== source/sample_sequencer.sv ====
/*
  auto-zero sample sequencer
  drives the pre-charge switch, azmux, led0 and the hi/lo sampling window
*/

`timescale 1ns/1ps
`default_nettype none

`include "acq_cfg.svh"

module sample_sequencer (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         run,
  input  wire [`ACQ_DUR_W-1:0]        sample_duration,
  input  wire [`ACQ_PC_W-1:0]         precharge_count,
  input  wire [`ACQ_AZMUX_W-1:0]      azmux_lo_val,
  output logic                        sw_pc_ctl,
  output logic                        led0,
  output logic [`ACQ_AZMUX_W-1:0]     azmux,
  output acq_pkg::seq_window_t        window
);

  acq_pkg::seq_state_t state;
  acq_pkg::seq_state_t next_state;

  // down counter for the current phase
  logic [`ACQ_DUR_W-1:0] count_down;
  // precharge count widened to the counter
  logic [`ACQ_DUR_W-1:0] pc_load;
  logic                  count_done;

  // registered azmux select, 1 picks the pre-charge output
  logic                  az_hi_sel;

  assign pc_load    = {{(`ACQ_DUR_W - `ACQ_PC_W){1'b0}}, precharge_count};
  assign count_done = (count_down == '0);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    case (state)
      acq_pkg::IDLE:            if (run) next_state = acq_pkg::PROTECT;
      // switch to boot, protect the signal
      acq_pkg::PROTECT:         next_state = acq_pkg::PROTECT_WAIT;
      acq_pkg::PROTECT_WAIT:    if (count_done) next_state = acq_pkg::PRECHARGE;
      // azmux to pc out while still at boot, settle
      acq_pkg::PRECHARGE:       next_state = acq_pkg::PRECHARGE_WAIT;
      acq_pkg::PRECHARGE_WAIT:  if (count_done) next_state = acq_pkg::HI_SAMPLE;
      // switch to signal, hi measurement
      acq_pkg::HI_SAMPLE:       next_state = acq_pkg::HI_WAIT;
      acq_pkg::HI_WAIT:         if (count_done) next_state = acq_pkg::RE_PROTECT;
      // back to boot before the azmux moves
      acq_pkg::RE_PROTECT:      next_state = acq_pkg::RE_PROTECT_WAIT;
      acq_pkg::RE_PROTECT_WAIT: if (count_done) next_state = acq_pkg::LO_SAMPLE;
      // azmux on lo, lo measurement
      acq_pkg::LO_SAMPLE:       next_state = acq_pkg::LO_WAIT;
      acq_pkg::LO_WAIT:         if (count_done) next_state = acq_pkg::CYCLE_END;
      // stop here at the end of a full pair while run is low
      acq_pkg::CYCLE_END:       if (run) next_state = acq_pkg::PRECHARGE;
      default:                  next_state = acq_pkg::IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state, counter and registered drives
  //////////////////////////////////////////////////////////////////////

  // drives are decoded from next_state, so they line up with the state
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state         <= acq_pkg::IDLE;
      count_down    <= '0;
      sw_pc_ctl     <= `ACQ_SW_PC_BOOT;
      az_hi_sel     <= 1'b0;
      led0          <= 1'b0;
      window.active <= 1'b0;
      window.phase  <= acq_pkg::PHASE_HI;
    end
    else
    begin
      state <= next_state;

      // entry states load, wait states count down to zero
      case (state)
        acq_pkg::PROTECT,
        acq_pkg::PRECHARGE,
        acq_pkg::RE_PROTECT:  count_down <= pc_load;
        acq_pkg::HI_SAMPLE,
        acq_pkg::LO_SAMPLE:   count_down <= sample_duration;
        default:              if (!count_done) count_down <= count_down - 1'b1;
      endcase

      // signal only for the hi window
      sw_pc_ctl <= (next_state == acq_pkg::HI_WAIT) ? `ACQ_SW_PC_SIGNAL : `ACQ_SW_PC_BOOT;

      // azmux leaves hi one cycle after the switch is back at boot
      az_hi_sel <= (next_state == acq_pkg::PRECHARGE)      ||
                   (next_state == acq_pkg::PRECHARGE_WAIT) ||
                   (next_state == acq_pkg::HI_SAMPLE)      ||
                   (next_state == acq_pkg::HI_WAIT)        ||
                   (next_state == acq_pkg::RE_PROTECT);

      // led on from hi sample until lo sample
      led0 <= (next_state == acq_pkg::HI_SAMPLE)  ||
              (next_state == acq_pkg::HI_WAIT)    ||
              (next_state == acq_pkg::RE_PROTECT) ||
              (next_state == acq_pkg::RE_PROTECT_WAIT);

      window.active <= (next_state == acq_pkg::HI_WAIT) || (next_state == acq_pkg::LO_WAIT);
      window.phase  <= (next_state == acq_pkg::LO_WAIT) ? acq_pkg::PHASE_LO : acq_pkg::PHASE_HI;
    end
  end

  // lo code follows the input directly
  assign azmux = az_hi_sel ? `ACQ_AZMUX_HI : azmux_lo_val;

endmodule

`default_nettype wire

// ==== source/acq_pkg.sv ====
/*
  acquisition types
  sequencer state and window phase enums, window, record and result structs
*/

`default_nettype none

`include "acq_cfg.svh"

package acq_pkg;

  // sequencer states, entry states are one cycle, wait states count down
  typedef enum logic [3:0] {
    IDLE,
    PROTECT,
    PROTECT_WAIT,
    PRECHARGE,
    PRECHARGE_WAIT,
    HI_SAMPLE,
    HI_WAIT,
    RE_PROTECT,
    RE_PROTECT_WAIT,
    LO_SAMPLE,
    LO_WAIT,
    CYCLE_END
  } seq_state_t;

  // which half of the auto-zero pair a window belongs to
  typedef enum logic [0:0] {
    PHASE_HI = 1'b0,
    PHASE_LO = 1'b1
  } phase_t;

  // sampling window from the sequencer
  typedef struct packed {
    logic   active;
    phase_t phase;
  } seq_window_t;

  // one record per closed window
  typedef struct packed {
    phase_t                  phase;
    logic [`ACQ_COUNT_W-1:0] count;
  } sample_rec_t;

  // hi count minus lo count, one extra bit for the sign
  typedef struct packed {
    logic signed [`ACQ_COUNT_W:0] diff;
  } az_result_t;

endpackage

`default_nettype wire

// ==== include/acq_cfg.svh ====
/*
  acquisition configuration macros
  counter widths, pre-charge switch levels, azmux hi code, fifo depth
*/

`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// width of the hi and lo sample duration
`define ACQ_DUR_W            32
// width of the precharge and protect count
`define ACQ_PC_W             24
// width of one converter pulse count
`define ACQ_COUNT_W          24

// azmux code width, and the code that selects the pre-charge output
`define ACQ_AZMUX_W          4
`define ACQ_AZMUX_HI         4'b1000

// pre-charge switch levels
`define ACQ_SW_PC_SIGNAL     1'b1
`define ACQ_SW_PC_BOOT       1'b0

// default fifo address width, 8 records
`define ACQ_FIFO_AW_DEFAULT  3

`endif
